//--- rtl/rvIsaPkg.sv
package rvIsaPkg;

    // Datapath and register file geometry
    localparam int XLEN       = 32;
    localparam int ILEN       = 32;   // Instruction word width
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int SHAMT_W    = 5;    // Shift amount taken from low bits of b

    // Major opcodes handled by the core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Funct3 for the integer operations
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_CSRRS   = 3'b010;  // Same code as SLT, SYSTEM opcode

    // Funct7 variants
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA

    // Read-only counter CSRs
    localparam logic [11:0] CSR_CYCLE    = 12'hC00;
    localparam logic [11:0] CSR_CYCLEH   = 12'hC80;
    localparam logic [11:0] CSR_INSTRET  = 12'hC02;
    localparam logic [11:0] CSR_INSTRETH = 12'hC82;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASSB   // Operand b straight through, LUI
    } aluOp_e;

endpackage

//--- rtl/execCtrlPkg.sv
package execCtrlPkg;

    // Sequencer states, one instruction at a time
    typedef enum logic [1:0] {
        IDLE,
        READ,
        EXEC,
        WB
    } execState_e;

    // Which half of which counter a CSR read returns
    typedef enum logic [1:0] {
        CYC_LO,
        CYC_HI,
        RET_LO,
        RET_HI
    } csrSel_e;

    // Decoder output, stable while the latched instruction is held
    typedef struct packed {
        rvIsaPkg::aluOp_e                aluOp;
        logic [rvIsaPkg::REG_ADDR_W-1:0] rs1;
        logic [rvIsaPkg::REG_ADDR_W-1:0] rs2;
        logic [rvIsaPkg::REG_ADDR_W-1:0] rd;
        logic [rvIsaPkg::XLEN-1:0]       imm;
        logic                            useImm;    // Operand b from imm
        logic                            isCsr;
        logic                            writesRd;
        logic                            legal;
        csrSel_e                         csrSel;
    } decodedOp_t;

    // Writeback record, also the observable result
    typedef struct packed {
        logic [rvIsaPkg::REG_ADDR_W-1:0] rd;
        logic [rvIsaPkg::XLEN-1:0]       data;
    } wbInfo_t;

endpackage

//--- rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            we_i,
    input  logic [rvIsaPkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rvIsaPkg::XLEN-1:0]       wdata_i,
    input  logic [rvIsaPkg::REG_ADDR_W-1:0] raddrA_i,
    input  logic [rvIsaPkg::REG_ADDR_W-1:0] raddrB_i,
    output logic [rvIsaPkg::XLEN-1:0]       rdataA_o,
    output logic [rvIsaPkg::XLEN-1:0]       rdataB_o
);
    import rvIsaPkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we_i && (waddr_i != '0))   // x0 never written
        begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Combinational reads, x0 forced to zero
    assign rdataA_o = (raddrA_i == '0) ? '0 : regs[raddrA_i];
    assign rdataB_o = (raddrB_i == '0) ? '0 : regs[raddrB_i];

endmodule

//--- rtl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic [rvIsaPkg::ILEN-1:0] instr_i,
    output execCtrlPkg::decodedOp_t   decoded_o
);
    import rvIsaPkg::*;
    import execCtrlPkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [11:0]     csrNum;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immU;
    aluOp_e          baseOp;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign csrNum = instr_i[31:20];
    assign immI   = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign immU   = {instr_i[31:12], 12'b0};

    // Operation implied by funct3 alone
    always_comb
    begin
        baseOp = ADD;
        case (funct3)
            F3_ADD_SUB: baseOp = ADD;
            F3_SLL:     baseOp = SLL;
            F3_SLT:     baseOp = SLT;
            F3_SLTU:    baseOp = SLTU;
            F3_XOR:     baseOp = XOR;
            F3_SRL_SRA: baseOp = SRL;
            F3_OR:      baseOp = OR;
            F3_AND:     baseOp = AND;
        endcase
    end

    always_comb
    begin
        decoded_o        = '0;
        decoded_o.aluOp  = baseOp;
        decoded_o.rs1    = instr_i[19:15];
        decoded_o.rs2    = instr_i[24:20];
        decoded_o.rd     = instr_i[11:7];
        decoded_o.imm    = immI;
        decoded_o.csrSel = CYC_LO;
        case (opcode)
            OPC_OP:
            begin
                decoded_o.writesRd = 1'b1;
                if (funct7 == F7_BASE)
                begin
                    decoded_o.legal = 1'b1;
                end
                else if (funct7 == F7_ALT && funct3 == F3_ADD_SUB)
                begin
                    decoded_o.legal = 1'b1;
                    decoded_o.aluOp = SUB;
                end
                else if (funct7 == F7_ALT && funct3 == F3_SRL_SRA)
                begin
                    decoded_o.legal = 1'b1;
                    decoded_o.aluOp = SRA;
                end
            end
            OPC_OP_IMM:
            begin
                decoded_o.writesRd = 1'b1;
                decoded_o.useImm   = 1'b1;
                decoded_o.legal    = 1'b1;
                // Shift immediates carry a funct7 in the upper bits
                if (funct3 == F3_SLL && funct7 != F7_BASE)
                begin
                    decoded_o.legal = 1'b0;
                end
                else if (funct3 == F3_SRL_SRA)
                begin
                    if (funct7 == F7_ALT)
                    begin
                        decoded_o.aluOp = SRA;
                    end
                    else if (funct7 != F7_BASE)
                    begin
                        decoded_o.legal = 1'b0;
                    end
                end
            end
            OPC_LUI:
            begin
                decoded_o.aluOp    = PASSB;
                decoded_o.rs1      = '0;    // Field is part of the immediate
                decoded_o.imm      = immU;
                decoded_o.useImm   = 1'b1;
                decoded_o.writesRd = 1'b1;
                decoded_o.legal    = 1'b1;
            end
            OPC_SYSTEM:
            begin
                decoded_o.aluOp    = ADD;
                decoded_o.isCsr    = 1'b1;
                decoded_o.writesRd = 1'b1;
                if (funct3 == F3_CSRRS && instr_i[19:15] == '0)
                begin
                    decoded_o.legal = 1'b1;
                    case (csrNum)
                        CSR_CYCLE:    decoded_o.csrSel = CYC_LO;
                        CSR_CYCLEH:   decoded_o.csrSel = CYC_HI;
                        CSR_INSTRET:  decoded_o.csrSel = RET_LO;
                        CSR_INSTRETH: decoded_o.csrSel = RET_HI;
                        default:      decoded_o.legal  = 1'b0;  // Unknown CSR
                    endcase
                end
            end
            default: decoded_o.legal = 1'b0;
        endcase
    end

endmodule

//--- rtl/intAlu.sv
`timescale 1ns/1ps

module intAlu (
    input  rvIsaPkg::aluOp_e          op_i,
    input  logic [rvIsaPkg::XLEN-1:0] a_i,
    input  logic [rvIsaPkg::XLEN-1:0] b_i,
    output logic [rvIsaPkg::XLEN-1:0] result_o
);
    import rvIsaPkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic               ltSigned;
    logic               ltUnsigned;

    assign shamt      = b_i[SHAMT_W-1:0];
    assign ltSigned   = $signed(a_i) < $signed(b_i);
    assign ltUnsigned = a_i < b_i;

    always_comb
    begin
        result_o = '0;
        case (op_i)
            ADD:   result_o = a_i + b_i;
            SUB:   result_o = a_i - b_i;
            SLL:   result_o = a_i << shamt;
            SLT:   result_o = {{(XLEN-1){1'b0}}, ltSigned};
            SLTU:  result_o = {{(XLEN-1){1'b0}}, ltUnsigned};
            XOR:   result_o = a_i ^ b_i;
            SRL:   result_o = a_i >> shamt;
            SRA:   result_o = $signed(a_i) >>> shamt;  // Sign bit replicated
            OR:    result_o = a_i | b_i;
            AND:   result_o = a_i & b_i;
            PASSB: result_o = b_i;
            default:
            begin
                result_o = '0;
            end
        endcase
    end

endmodule

//--- rtl/perfCounters.sv
`timescale 1ns/1ps

module perfCounters (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      retire_i,
    input  execCtrlPkg::csrSel_e      sel_i,
    output logic [rvIsaPkg::XLEN-1:0] csrData_o
);
    import rvIsaPkg::*;
    import execCtrlPkg::*;

    logic [2*XLEN-1:0] cycleCnt;
    logic [2*XLEN-1:0] instretCnt;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cycleCnt   <= '0;
            instretCnt <= '0;
        end
        else
        begin
            cycleCnt <= cycleCnt + 1'b1;    // Every edge out of reset
            if (retire_i)
            begin
                instretCnt <= instretCnt + 1'b1;
            end
        end
    end

    // Half select for the CSR read
    always_comb
    begin
        case (sel_i)
            CYC_LO:  csrData_o = cycleCnt[XLEN-1:0];
            CYC_HI:  csrData_o = cycleCnt[2*XLEN-1:XLEN];
            RET_LO:  csrData_o = instretCnt[XLEN-1:0];
            RET_HI:  csrData_o = instretCnt[2*XLEN-1:XLEN];
            default: csrData_o = '0;
        endcase
    end

endmodule

//--- rtl/execFsm.sv
`timescale 1ns/1ps

module execFsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instrValid_i,
    input  logic [rvIsaPkg::ILEN-1:0] instr_i,
    input  execCtrlPkg::decodedOp_t   decoded_i,
    output logic [rvIsaPkg::ILEN-1:0] instrLatched_o,
    input  logic [rvIsaPkg::XLEN-1:0] rs1Data_i,
    input  logic [rvIsaPkg::XLEN-1:0] rs2Data_i,
    input  logic [rvIsaPkg::XLEN-1:0] aluResult_i,
    input  logic [rvIsaPkg::XLEN-1:0] csrData_i,
    output logic [rvIsaPkg::XLEN-1:0] aluA_o,
    output logic [rvIsaPkg::XLEN-1:0] aluB_o,
    output logic                      rfWe_o,
    output execCtrlPkg::wbInfo_t      wbInfo_o,
    output logic                      retire_o,
    output logic                      illegal_o,
    output logic                      busy_o
);
    import rvIsaPkg::*;
    import execCtrlPkg::*;

    execState_e      state;
    execState_e      stateNext;
    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] csrLatched;
    logic            inWb;

    always_comb
    begin
        stateNext = state;
        case (state)
            IDLE:    stateNext = instrValid_i ? READ : IDLE;
            READ:    stateNext = EXEC;
            EXEC:    stateNext = WB;
            WB:      stateNext = IDLE;
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= stateNext;
        end
    end

    // Instruction and operand registers
    always_ff @(posedge clk)
    begin
        if (state == IDLE && instrValid_i)
        begin
            instrLatched_o <= instr_i;
        end
        if (state == READ)
        begin
            opA        <= rs1Data_i;
            opB        <= decoded_i.useImm ? decoded_i.imm : rs2Data_i;
            csrLatched <= csrData_i;    // Counter value seen at the capture edge
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wbInfo_o <= '0;
        end
        else if (state == EXEC && decoded_i.legal)
        begin
            wbInfo_o.rd   <= decoded_i.rd;
            wbInfo_o.data <= decoded_i.isCsr ? csrLatched : aluResult_i;
        end
    end

    assign aluA_o    = opA;
    assign aluB_o    = opB;
    assign inWb      = (state == WB);
    assign retire_o  = inWb && decoded_i.legal;
    assign illegal_o = inWb && !decoded_i.legal;
    assign rfWe_o    = retire_o && decoded_i.writesRd;
    assign busy_o    = (state != IDLE);

endmodule

//--- rtl/execCore.sv
`timescale 1ns/1ps

module execCore (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instrValid_i,
    input  logic [rvIsaPkg::ILEN-1:0] instr_i,
    output logic                      busy_o,
    output logic                      retired_o,
    output logic                      illegal_o,
    output execCtrlPkg::wbInfo_t      wbInfo_o
);
    import rvIsaPkg::*;
    import execCtrlPkg::*;

    decodedOp_t      decoded;
    logic [ILEN-1:0] instrLatched;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [XLEN-1:0] aluA;
    logic [XLEN-1:0] aluB;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] csrData;
    logic            rfWe;

    instrDecoder u_decoder (
        .instr_i   (instrLatched),
        .decoded_o (decoded)
    );

    // Write port driven from the registered writeback record
    regFile u_regFile (
        .clk      (clk),
        .rst_n    (rst_n),
        .we_i     (rfWe),
        .waddr_i  (wbInfo_o.rd),
        .wdata_i  (wbInfo_o.data),
        .raddrA_i (decoded.rs1),
        .raddrB_i (decoded.rs2),
        .rdataA_o (rs1Data),
        .rdataB_o (rs2Data)
    );

    intAlu u_alu (
        .op_i     (decoded.aluOp),
        .a_i      (aluA),
        .b_i      (aluB),
        .result_o (aluResult)
    );

    perfCounters u_perfCounters (
        .clk       (clk),
        .rst_n     (rst_n),
        .retire_i  (retired_o),
        .sel_i     (decoded.csrSel),
        .csrData_o (csrData)
    );

    execFsm u_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .instrValid_i   (instrValid_i),
        .instr_i        (instr_i),
        .decoded_i      (decoded),
        .instrLatched_o (instrLatched),
        .rs1Data_i      (rs1Data),
        .rs2Data_i      (rs2Data),
        .aluResult_i    (aluResult),
        .csrData_i      (csrData),
        .aluA_o         (aluA),
        .aluB_o         (aluB),
        .rfWe_o         (rfWe),
        .wbInfo_o       (wbInfo_o),
        .retire_o       (retired_o),
        .illegal_o      (illegal_o),
        .busy_o         (busy_o)
    );

endmodule

//--- verification/execCoreRef.svh
`ifndef EXEC_CORE_REF_SVH
`define EXEC_CORE_REF_SVH

// Instruction fields as the RV32I encoding tables lay them out
typedef struct packed {
    logic        legal;
    logic        isLui;
    logic        isCsr;
    logic        useImm;
    logic        alt;       // SUB or SRA variant
    logic [2:0]  funct3;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic [11:0] csrNum;
} refDec_t;

function automatic refDec_t refDecode(input logic [31:0] word);
    refDec_t    d;
    logic [6:0] f7;
    f7       = word[31:25];
    d        = '0;
    d.funct3 = word[14:12];
    d.rs1    = word[19:15];
    d.rs2    = word[24:20];
    d.rd     = word[11:7];
    d.imm    = {{20{word[31]}}, word[31:20]};
    d.csrNum = word[31:20];
    case (word[6:0])
        7'b0110011:
        begin
            d.alt   = (f7 == 7'h20);
            d.legal = (f7 == 7'h00) || (d.alt && (d.funct3 == 3'd0 || d.funct3 == 3'd5));
        end
        7'b0010011:
        begin
            d.useImm = 1'b1;
            d.alt    = (d.funct3 == 3'd5) && (f7 == 7'h20);
            d.legal  = (d.funct3 == 3'd1) ? (f7 == 7'h00) :
                       (d.funct3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
        end
        7'b0110111:
        begin
            d.isLui  = 1'b1;
            d.useImm = 1'b1;
            d.imm    = {word[31:12], 12'h000};
            d.legal  = 1'b1;
        end
        7'b1110011:
        begin
            d.isCsr = 1'b1;
            // Only read-only counters through CSRRS with rs1 = x0
            d.legal = (d.funct3 == 3'b010) && (d.rs1 == 5'd0) &&
                      (d.csrNum == 12'hC00 || d.csrNum == 12'hC80 ||
                       d.csrNum == 12'hC02 || d.csrNum == 12'hC82);
        end
        default: d.legal = 1'b0;
    endcase
    return d;
endfunction

function automatic logic [31:0] refAlu(input logic [2:0] funct3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (funct3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << sh;
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: return (a < b) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5:
        begin
            if (alt)
                return $signed(a) >>> sh;   // Kept apart from the logical shift
            return a >> sh;
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// Expected writeback from the shadow registers and the testbench's own counts
function automatic wbInfo_t refExec(input logic [31:0] word, input logic [63:0] cyc,
                                    input logic [63:0] ret);
    refDec_t     d;
    logic [31:0] a;
    logic [31:0] b;
    wbInfo_t     wb;
    d     = refDecode(word);
    a     = shadowRegs[d.rs1];
    b     = d.useImm ? d.imm : shadowRegs[d.rs2];
    wb.rd = d.rd;
    if (d.isLui)
        wb.data = d.imm;
    else if (d.isCsr)
    begin
        case (d.csrNum)
            12'hC00: wb.data = cyc[31:0];
            12'hC80: wb.data = cyc[63:32];
            12'hC02: wb.data = ret[31:0];
            default: wb.data = ret[63:32];
        endcase
    end
    else
        wb.data = refAlu(d.funct3, d.alt, a, b);
    return wb;
endfunction

`endif

//--- verification/execCoreTb.sv
`timescale 1ns/1ps

module execCoreTb;
    import rvIsaPkg::*;
    import execCtrlPkg::*;

    localparam int SEED           = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_PAIRS      = 40;
    localparam int NUM_RANDOM     = 300;
    localparam int NUM_ILLEGAL    = 40;
    localparam int NUM_CSR_ROUNDS = 6;
    // Three full register reads plus every phase's own instructions
    localparam int NUM_INSTR = 3 * 32 + 31 + 2 * NUM_PAIRS + 5 + NUM_RANDOM
                               + NUM_ILLEGAL + 4 + 6 * NUM_CSR_ROUNDS;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + 200;

    logic        clk;
    logic        rst_n;
    logic        instrValid_i;
    logic [31:0] instr_i;
    logic        busy_o;
    logic        retired_o;
    logic        illegal_o;
    wbInfo_t     wbInfo_o;

    logic [31:0] shadowRegs [32];
    logic [63:0] edgeCount;     // Rising edges since reset release
    logic [63:0] retireCount;
    string       expName [$];
    logic        expLegal [$];
    wbInfo_t     expWb [$];

    `include "execCoreRef.svh"

    execCore u_execCore (
        .clk          (clk),
        .rst_n        (rst_n),
        .instrValid_i (instrValid_i),
        .instr_i      (instr_i),
        .busy_o       (busy_o),
        .retired_o    (retired_o),
        .illegal_o    (illegal_o),
        .wbInfo_o     (wbInfo_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (!rst_n)
            edgeCount <= '0;
        else
            edgeCount <= edgeCount + 64'd1;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic reportMismatch(input string name, input string what,
                                  input logic [31:0] expVal, input logic [31:0] actVal);
        failRun($sformatf("mismatch %s %s expected %h actual %h", name, what, expVal, actVal));
    endtask

    function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [2:0] f3,
                                              input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [2:0] f3,
                                              input int rd, input int rs1);
        return {imm, 5'(rs1), f3, 5'(rd), OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] luiWord(input logic [19:0] imm, input int rd);
        return {imm, 5'(rd), OPC_LUI};
    endfunction

    function automatic logic [31:0] csrReadWord(input logic [11:0] csr, input int rd,
                                                input int rs1);
        return {csr, 5'(rs1), 3'b010, 5'(rd), OPC_SYSTEM};
    endfunction

    function automatic logic [31:0] randomLegalWord();
        int          kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        kind = $urandom_range(0, 9);
        f3   = 3'($urandom());
        f7   = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
        imm  = 12'($urandom());
        if (kind < 5)
            return rTypeWord(f7, f3, $urandom_range(0, 31), $urandom_range(0, 31),
                             $urandom_range(0, 31));
        if (kind < 9)
        begin
            if (f3 == 3'd1 || f3 == 3'd5)
                imm[11:5] = (f3 == 3'd5) ? f7 : 7'h00;   // Shift funct7 in the top bits
            return iTypeWord(imm, f3, $urandom_range(0, 31), $urandom_range(0, 31));
        end
        return luiWord(20'($urandom()), $urandom_range(0, 31));
    endfunction

    function automatic logic [31:0] randomIllegalWord();
        logic [31:0] word;
        refDec_t     dec;
        do
        begin
            word = $urandom();
            dec  = refDecode(word);
        end
        while (dec.legal);
        return word;
    endfunction

    // Starts on a falling edge with the core idle and returns once it is idle again
    task automatic sendInstr(input string name, input logic [31:0] word);
        refDec_t dec;
        dec = refDecode(word);
        expName.push_back(name);
        expLegal.push_back(dec.legal);
        // Capture edge A+1 is the second rising edge from here
        expWb.push_back(refExec(word, edgeCount + 64'd1, retireCount));
        instrValid_i = 1'b1;
        instr_i      = word;
        @(negedge clk);
        instrValid_i = 1'b0;
        instr_i      = $urandom();  // Core must hold its own copy while busy
        assert (busy_o) else failRun("busy_o did not rise after an instruction strobe");
        while (busy_o || expLegal.size() != 0)
            @(negedge clk);
    endtask

    task automatic readAllRegs(input string name);
        for (int r = 0; r < 32; r++)
            sendInstr(name, rTypeWord(7'h00, 3'b000, 0, r, 0));     // ADD x0, xr, x0
    endtask

    // One pulse per instruction in the WB state
    initial
    begin
        string   name;
        logic    legal;
        wbInfo_t wb;
        forever
        begin
            @(negedge clk);
            if (rst_n && (retired_o || illegal_o))
            begin
                assert (expLegal.size() > 0)
                    else failRun("retired_o or illegal_o pulsed with no instruction pending");
                name  = expName.pop_front();
                legal = expLegal.pop_front();
                wb    = expWb.pop_front();
                assert (retired_o == legal)
                    else reportMismatch(name, "retired_o", 32'(legal), 32'(retired_o));
                assert (illegal_o == !legal)
                    else reportMismatch(name, "illegal_o", 32'(!legal), 32'(illegal_o));
                if (legal)
                begin
                    assert (wbInfo_o.rd == wb.rd)
                        else reportMismatch(name, "rd", 32'(wb.rd), 32'(wbInfo_o.rd));
                    assert (wbInfo_o.data == wb.data)
                        else reportMismatch(name, "data", wb.data, wbInfo_o.data);
                    retireCount = retireCount + 64'd1;
                    if (wb.rd != 5'd0)
                        shadowRegs[wb.rd] = wb.data;
                end
            end
        end
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        failRun("timeout, the core stopped responding before the tests completed");
    end

    initial
    begin
        void'($urandom(SEED));
        rst_n        = 1'b0;
        instrValid_i = 1'b0;
        instr_i      = '0;
        retireCount  = '0;
        for (int r = 0; r < 32; r++)
            shadowRegs[r] = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        assert (!busy_o && !retired_o && !illegal_o)
            else failRun("busy_o, retired_o or illegal_o high after reset");
        assert (wbInfo_o.rd == '0) else reportMismatch("reset", "rd", 32'h0, 32'(wbInfo_o.rd));
        assert (wbInfo_o.data == '0) else reportMismatch("reset", "data", 32'h0, wbInfo_o.data);
        readAllRegs("reset read");

        for (int r = 1; r < 32; r++)
            sendInstr("addi write", iTypeWord(12'($urandom()), 3'b000, r, 0));
        for (int p = 0; p < NUM_PAIRS; p++)
        begin
            sendInstr("add pair", rTypeWord(7'h00, 3'b000, $urandom_range(1, 31),
                                            $urandom_range(0, 31), $urandom_range(0, 31)));
            sendInstr("or pair", rTypeWord(7'h00, 3'b110, $urandom_range(1, 31),
                                           $urandom_range(0, 31), $urandom_range(0, 31)));
        end
        readAllRegs("register read");

        sendInstr("x0 write", iTypeWord(12'h5A5, 3'b000, 0, 0));
        sendInstr("x0 write", luiWord(20'hABCDE, 0));
        sendInstr("x0 write", rTypeWord(7'h00, 3'b110, 0, 3, 4));
        sendInstr("x0 read", rTypeWord(7'h00, 3'b000, 9, 0, 0));
        sendInstr("x0 read", iTypeWord(12'h000, 3'b110, 10, 0));

        repeat (NUM_RANDOM) sendInstr("random alu", randomLegalWord());

        repeat (NUM_ILLEGAL) sendInstr("illegal random", randomIllegalWord());
        sendInstr("illegal csrrs rs1", csrReadWord(CSR_CYCLE, 5, 7));
        sendInstr("illegal csr number", csrReadWord(12'h300, 5, 0));
        sendInstr("illegal funct7", rTypeWord(7'h01, 3'b000, 6, 1, 2));
        sendInstr("illegal slli", iTypeWord(12'h403, 3'b001, 6, 1));
        readAllRegs("read after illegal");

        // Idle gaps move the cycle count between reads
        for (int k = 0; k < NUM_CSR_ROUNDS; k++)
        begin
            sendInstr("addi filler", iTypeWord(12'($urandom()), 3'b000, 11, 11));
            sendInstr("rdinstret", csrReadWord(CSR_INSTRET, 12, 0));
            repeat ($urandom_range(0, 3)) @(negedge clk);
            sendInstr("rdcycle", csrReadWord(CSR_CYCLE, 13, 0));
            sendInstr("rdinstreth", csrReadWord(CSR_INSTRETH, 14, 0));
            repeat ($urandom_range(0, 3)) @(negedge clk);
            sendInstr("rdcycleh", csrReadWord(CSR_CYCLEH, 15, 0));
            sendInstr("counter sum", rTypeWord(7'h00, 3'b000, 16, 12, 13));
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- files.f
+incdir+verification
rtl/rvIsaPkg.sv
rtl/execCtrlPkg.sv
rtl/regFile.sv
rtl/instrDecoder.sv
rtl/intAlu.sv
rtl/perfCounters.sv
rtl/execFsm.sv
rtl/execCore.sv
verification/execCoreTb.sv

//--- Bender.yml
package:
  name: exec_core

sources:
  - rtl/rvIsaPkg.sv
  - rtl/execCtrlPkg.sv
  - rtl/regFile.sv
  - rtl/instrDecoder.sv
  - rtl/intAlu.sv
  - rtl/perfCounters.sv
  - rtl/execFsm.sv
  - rtl/execCore.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/execCoreTb.sv
